/* compile.f */
hdl/batrider_map_pkg.sv
hdl/batrider_io_pkg.sv
hdl/region_bus_if.sv
hdl/bus_decoder.sv
hdl/byte_lane_ram.sv
hdl/io_ports.sv
hdl/gcu_port.sv
hdl/batrider_main_bus.sv
sim/tb_batrider_main_bus.sv

/* Bender.yml */
package:
  name: batrider_main_bus

sources:
  - hdl/batrider_map_pkg.sv
  - hdl/batrider_io_pkg.sv
  - hdl/region_bus_if.sv
  - hdl/bus_decoder.sv
  - hdl/byte_lane_ram.sv
  - hdl/io_ports.sv
  - hdl/gcu_port.sv
  - hdl/batrider_main_bus.sv
  - target: test
    files:
      - sim/tb_batrider_main_bus.sv

/* sim/tb_batrider_main_bus.sv */
// main bus testbench
`timescale 1ns/1ns

module tb_batrider_main_bus import batrider_map_pkg::*, batrider_io_pkg::*; ();

    localparam int ACK_TIMEOUT = 50;

    logic        CLK96, RESET96;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [1:0]  wb_sel;
    logic [23:1] wb_adr;
    logic [15:0] wb_dat_w, wb_dat_r;
    logic [9:0]  joystick1, joystick2;
    logic [3:0]  start_button, coin_input;
    logic        service, dip_test, hsync, vsync, fblank, snd_irq_in, snd_irq;
    logic [7:0]  dipsw_a, dipsw_b, dipsw_c, sound_latch3, sound_latch4;
    logic [8:0]  v_count;
    logic [7:0]  sound_latch, sound_latch2;
    logic [15:0] z80_busreq, gcu_dout;
    logic        gcu_ack;
    logic        op_wr_reg, op_sel_reg, op_wr_ram, op_rd_h, op_rd_l, op_ptr;
    logic [5:0]  ops;        // {ptr, read_l, read_h, write_ram, select, write_reg}

    int          errors, timeouts, last_lat, gcu_delay, op_hits;
    logic [5:0]  seen_ops;
    logic        op_unstable;
    logic [15:0] text_model [logic [13:0]];
    logic [15:0] work_model [logic [13:0]];
    logic [13:0] idx_list [$];

    assign ops = {op_ptr, op_rd_l, op_rd_h, op_wr_ram, op_sel_reg, op_wr_reg};

    batrider_main_bus DUT (
        .CLK96(CLK96), .RESET96(RESET96),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .v_count(v_count), .hsync(hsync), .vsync(vsync), .fblank(fblank),
        .sound_latch3(sound_latch3), .sound_latch4(sound_latch4), .snd_irq_in(snd_irq_in),
        .sound_latch(sound_latch), .sound_latch2(sound_latch2),
        .z80_busreq(z80_busreq), .snd_irq(snd_irq),
        .gcu_ack(gcu_ack), .gcu_dout(gcu_dout),
        .gcu_op_write_reg(op_wr_reg), .gcu_op_select_reg(op_sel_reg),
        .gcu_op_write_ram(op_wr_ram), .gcu_op_read_ram_h(op_rd_h),
        .gcu_op_read_ram_l(op_rd_l), .gcu_op_set_ram_ptr(op_ptr)
    );

    initial begin
        CLK96 = 1'b0;
        forever #4 CLK96 = ~CLK96;
    end

    // video chip model acks a raised op after gcu_delay cycles
    initial begin
        gcu_ack = 1'b0;
        forever begin
            @(negedge CLK96);
            if (ops != 6'b0) begin
                seen_ops = ops;
                op_hits++;
                repeat (gcu_delay) begin
                    @(negedge CLK96);
                    if (ops != seen_ops) op_unstable = 1'b1;
                end
                @(posedge CLK96);
                gcu_ack <= 1'b1;
                @(negedge CLK96);
                if (ops != seen_ops) op_unstable = 1'b1; // must hold through the ack
                @(posedge CLK96);
                gcu_ack <= 1'b0;
            end
        end
    end

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [23:0] ram_addr(input logic bank, input logic [13:0] idx);
        ram_addr = {REGION_RAM, 4'h0, bank, idx, 1'b0};
    endfunction

    function automatic logic [15:0] lane_merge(input logic [15:0] old_w, input logic [15:0] new_w,
                                               input logic [1:0] sel);
        lane_merge[15:8] = sel[1] ? new_w[15:8] : old_w[15:8];
        lane_merge[7:0]  = sel[0] ? new_w[7:0] : old_w[7:0];
    endfunction

    function automatic logic [7:0] expected_player(input logic [9:0] j);
        expected_player = {1'b0, ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    // one Wishbone classic transfer
    task automatic bus_cycle(input logic we, input logic [1:0] sel, input logic [23:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int   n;
        logic got;
        n = 0;
        got = 1'b0;
        rdata = '0;
        @(posedge CLK96);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_sel   <= sel;
        wb_adr   <= addr[23:1];
        wb_dat_w <= wdata;
        while (!got && n < ACK_TIMEOUT) begin
            @(negedge CLK96);
            n++;
            got = wb_ack;
        end
        if (got) begin
            rdata = wb_dat_r;
            last_lat = n - 1; // cycles from strobe to ack
        end else begin
            $display("timeout: no wb_ack for the access at address %h", addr);
            timeouts++;
            last_lat = -1;
        end
        @(posedge CLK96);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [23:0] addr, input logic [15:0] data,
                             input logic [1:0] sel);
        logic [15:0] unused;
        bus_cycle(1'b1, sel, addr, data, unused);
    endtask

    task automatic bus_read(input logic [23:0] addr, output logic [15:0] data);
        bus_cycle(1'b0, 2'b11, addr, 16'h0000, data);
    endtask

    task automatic ram_byte_lanes();
        int          i;
        logic [13:0] idx;
        logic [15:0] d, rd;
        logic [1:0]  sel;
        for (i = 0; i < 8; i++) begin
            idx = 14'($urandom);
            idx_list.push_back(idx);
            d = 16'($urandom);
            bus_write(ram_addr(1'b0, idx), d, 2'b11);
            text_model[idx] = d;
            d = 16'($urandom);
            bus_write(ram_addr(1'b1, idx), d, 2'b11); // same index in work RAM
            work_model[idx] = d;
            sel = $urandom_range(1, 0) ? 2'b10 : 2'b01;
            d = 16'($urandom);
            bus_write(ram_addr(1'b0, idx), d, sel);
            text_model[idx] = lane_merge(text_model[idx], d, sel);
        end
        foreach (idx_list[k]) begin
            idx = idx_list[k];
            bus_read(ram_addr(1'b0, idx), rd);
            if (rd !== text_model[idx])
                report_error($sformatf("text RAM %h read %h, expected %h", idx, rd,
                                       text_model[idx]));
            if (last_lat != 2)
                report_error($sformatf("text RAM read ack after %0d cycles", last_lat));
            bus_read(ram_addr(1'b1, idx), rd);
            if (rd !== work_model[idx])
                report_error($sformatf("work RAM %h read %h, expected %h", idx, rd,
                                       work_model[idx]));
            if (last_lat != 2)
                report_error($sformatf("work RAM read ack after %0d cycles", last_lat));
        end
    endtask

    task automatic input_mapping();
        int          i;
        logic [15:0] rd, exp;
        for (i = 0; i < 6; i++) begin
            @(posedge CLK96);
            joystick1    <= 10'($urandom);
            joystick2    <= 10'($urandom);
            start_button <= 4'($urandom);
            coin_input   <= 4'($urandom);
            service      <= 1'($urandom);
            dip_test     <= 1'($urandom);
            dipsw_a      <= 8'($urandom);
            dipsw_b      <= 8'($urandom);
            dipsw_c      <= 8'($urandom);
            bus_read({16'h5000, IO_INPUTS}, rd);
            exp = {expected_player(joystick2), expected_player(joystick1)};
            if (rd !== exp) report_error($sformatf("inputs %h, expected %h", rd, exp));
            bus_read({16'h5000, IO_SYS_DSW}, rd);
            exp = {dipsw_c, 1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                   ~coin_input[0], ~dip_test, 1'b0, ~service};
            if (rd !== exp) report_error($sformatf("system word %h, expected %h", rd, exp));
            bus_read({16'h5000, IO_DSW}, rd);
            if (rd !== {dipsw_b, dipsw_a})
                report_error($sformatf("DIP word %h, expected %h", rd, {dipsw_b, dipsw_a}));
        end
    endtask

    task automatic video_status_sweep();
        int          i;
        logic [15:0] rd, exp;
        for (i = 0; i < 8; i++) begin
            @(posedge CLK96);
            v_count <= (i == 7) ? 9'd256 : 9'(i * 85); // both sides of the line limit
            hsync   <= 1'($urandom);
            vsync   <= 1'($urandom);
            fblank  <= 1'($urandom);
            bus_read({16'h5000, IO_VSTATUS}, rd);
            exp = {hsync, vsync, 5'h1F, fblank, (v_count < 256) ? v_count[7:0] : 8'hFF};
            if (rd !== exp) report_error($sformatf("status %h, expected %h", rd, exp));
        end
    endtask

    task automatic sound_registers();
        int          n;
        logic [15:0] d, rd;
        d = 16'($urandom);
        bus_write({16'h5000, IO_SNDLATCH}, d, 2'b11);
        if (sound_latch !== d[7:0]) report_error("sound_latch not written");
        d = 16'($urandom);
        bus_write({16'h5000, IO_SNDLATCH2}, d, 2'b11);
        if (sound_latch2 !== d[7:0]) report_error("sound_latch2 not written");
        d = 16'($urandom);
        bus_write({16'h5000, IO_BUSREQ_WR}, d, 2'b11);
        if (z80_busreq !== d) report_error("z80_busreq not written");
        bus_read({16'h5000, IO_BUSREQ_RD}, rd);
        if (rd !== d) report_error($sformatf("busreq readback %h, expected %h", rd, d));
        @(posedge CLK96);
        sound_latch3 <= 8'($urandom);
        sound_latch4 <= 8'($urandom);
        bus_read({16'h5000, IO_SNDLATCH3}, rd);
        if (rd !== {8'h00, sound_latch3}) report_error($sformatf("latch 3 read %h", rd));
        bus_read({16'h5000, IO_SNDLATCH4}, rd);
        if (rd !== {8'h00, sound_latch4}) report_error($sformatf("latch 4 read %h", rd));
        @(posedge CLK96);
        snd_irq_in <= 1'b1;
        @(posedge CLK96);
        snd_irq_in <= 1'b0;
        n = 0;
        while (!snd_irq && n < 20) begin
            @(negedge CLK96);
            n++;
        end
        if (!snd_irq) begin
            $display("timeout: snd_irq never rose after a pulse on snd_irq_in");
            timeouts++;
        end
        bus_write({16'h5000, IO_CLR_SNDIRQ}, 16'h0000, 2'b11);
        @(negedge CLK96);
        if (snd_irq !== 1'b0) report_error("snd_irq still set after the clear write");
    endtask

    task automatic gcu_commands();
        int          i, hits;
        logic [3:0]  ofs;
        logic        we;
        logic [5:0]  exp_op;
        logic [15:0] d, rd;
        for (i = 0; i < 7; i++) begin
            case (i)
                0: begin ofs = GCU_WRITE_REG;  we = 1'b1; exp_op = 6'b000001; end
                1: begin ofs = GCU_SELECT_REG; we = 1'b1; exp_op = 6'b000010; end
                2: begin ofs = GCU_RAM_H;      we = 1'b1; exp_op = 6'b000100; end
                3: begin ofs = GCU_RAM_L;      we = 1'b1; exp_op = 6'b000100; end
                4: begin ofs = GCU_RAM_PTR;    we = 1'b1; exp_op = 6'b100000; end
                5: begin ofs = GCU_RAM_H;      we = 1'b0; exp_op = 6'b001000; end
                default: begin ofs = GCU_RAM_L; we = 1'b0; exp_op = 6'b010000; end
            endcase
            gcu_delay = $urandom_range(6, 0);
            op_unstable = 1'b0;
            hits = op_hits;
            d = 16'($urandom);
            @(posedge CLK96);
            gcu_dout <= d;
            bus_cycle(we, 2'b11, {20'h40000, ofs}, 16'($urandom), rd);
            if (op_hits != hits + 1)
                report_error($sformatf("offset %h raised %0d ops", ofs, op_hits - hits));
            if (seen_ops !== exp_op || op_unstable)
                report_error($sformatf("offset %h op %b, expected %b", ofs, seen_ops, exp_op));
            if (ops !== 6'b0) report_error("op strobe still high after the ack");
            if (!we && rd !== d)
                report_error($sformatf("gcu read %h, expected %h", rd, d));
        end
        hits = op_hits;
        bus_read(24'h400002, rd); // offset with no operation
        if (rd !== 16'h0000 || op_hits != hits) report_error("gcu no-op offset misbehaved");
        bus_read(24'h300000, rd);
        if (rd !== 16'h0000 || last_lat != 2)
            report_error($sformatf("unmapped read %h after %0d cycles", rd, last_lat));
        bus_read(24'h500010, rd);
        if (rd !== 16'h0000) report_error("unused I/O offset not zero");
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        op_hits = 0;
        gcu_delay = 0;
        void'($urandom(65));
        RESET96 = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_sel = 2'b00;
        wb_adr = '0;
        wb_dat_w = '0;
        joystick1 = '1;
        joystick2 = '1;
        start_button = '1;
        coin_input = '1;
        service = 1'b1;
        dip_test = 1'b1;
        dipsw_a = '0;
        dipsw_b = '0;
        dipsw_c = '0;
        v_count = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        fblank = 1'b0;
        sound_latch3 = '0;
        sound_latch4 = '0;
        snd_irq_in = 1'b0;
        gcu_dout = '0;
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(negedge CLK96);
        if (wb_ack !== 1'b0 || ops !== 6'b0 || snd_irq !== 1'b0)
            report_error("outputs not idle after reset");
        if (sound_latch !== 8'h00 || sound_latch2 !== 8'h00 || z80_busreq !== 16'h0000)
            report_error("sound registers not cleared by reset");
        ram_byte_lanes();
        input_mapping();
        video_status_sweep();
        sound_registers();
        gcu_commands();
        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* hdl/batrider_main_bus.sv */
// twin CPU board main bus
`timescale 1ns/1ns

module batrider_main_bus import batrider_map_pkg::*; (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [SEL_W-1:0]    wb_sel,
    input  logic [ADDR_W-1:1]   wb_adr,
    input  logic [DATA_W-1:0]   wb_dat_w,
    output logic [DATA_W-1:0]   wb_dat_r,
    output logic                wb_ack,
    input  logic [9:0]          joystick1,
    input  logic [9:0]          joystick2,
    input  logic [3:0]          start_button,
    input  logic [3:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    input  logic [7:0]          dipsw_c,
    input  logic [8:0]          v_count,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                fblank,
    input  logic [7:0]          sound_latch3,
    input  logic [7:0]          sound_latch4,
    input  logic                snd_irq_in,
    output logic [7:0]          sound_latch,
    output logic [7:0]          sound_latch2,
    output logic [15:0]         z80_busreq,
    output logic                snd_irq,
    input  logic                gcu_ack,
    input  logic [DATA_W-1:0]   gcu_dout,
    output logic                gcu_op_write_reg,
    output logic                gcu_op_select_reg,
    output logic                gcu_op_write_ram,
    output logic                gcu_op_read_ram_h,
    output logic                gcu_op_read_ram_l,
    output logic                gcu_op_set_ram_ptr
);

    region_bus_if text_bus ();
    region_bus_if work_bus ();
    region_bus_if io_bus ();
    region_bus_if gcu_bus ();

    bus_decoder u_decoder (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .text_ram (text_bus),
        .work_ram (work_bus),
        .io       (io_bus),
        .gcu      (gcu_bus)
    );

    byte_lane_ram u_text_ram (.CLK96(CLK96), .RESET96(RESET96), .bus(text_bus)); // 0x200000
    byte_lane_ram u_work_ram (.CLK96(CLK96), .RESET96(RESET96), .bus(work_bus)); // 0x208000

    io_ports u_io (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .bus          (io_bus),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .v_count      (v_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .sound_latch3 (sound_latch3),
        .sound_latch4 (sound_latch4),
        .snd_irq_in   (snd_irq_in),
        .sound_latch  (sound_latch),
        .sound_latch2 (sound_latch2),
        .z80_busreq   (z80_busreq),
        .snd_irq      (snd_irq)
    );

    gcu_port u_gcu (
        .CLK96              (CLK96),
        .RESET96            (RESET96),
        .bus                (gcu_bus),
        .gcu_ack            (gcu_ack),
        .gcu_dout           (gcu_dout),
        .gcu_op_write_reg   (gcu_op_write_reg),
        .gcu_op_select_reg  (gcu_op_select_reg),
        .gcu_op_write_ram   (gcu_op_write_ram),
        .gcu_op_read_ram_h  (gcu_op_read_ram_h),
        .gcu_op_read_ram_l  (gcu_op_read_ram_l),
        .gcu_op_set_ram_ptr (gcu_op_set_ram_ptr)
    );

endmodule

/* hdl/gcu_port.sv */
// video controller command port
`timescale 1ns/1ns

module gcu_port import batrider_map_pkg::*, batrider_io_pkg::*; (
    input  logic              CLK96,
    input  logic              RESET96,
    region_bus_if.slave       bus,
    input  logic              gcu_ack,
    input  logic [DATA_W-1:0] gcu_dout,
    output logic              gcu_op_write_reg,
    output logic              gcu_op_select_reg,
    output logic              gcu_op_write_ram,
    output logic              gcu_op_read_ram_h,
    output logic              gcu_op_read_ram_l,
    output logic              gcu_op_set_ram_ptr
);

    logic [3:0]        ofs;
    logic [5:0]        op_dec; // {ptr, read_l, read_h, write_ram, select, write_reg}
    logic [5:0]        op_q;
    logic [DATA_W-1:0] dat_q;
    logic              ack_q;
    logic              busy;
    logic              start;

    assign ofs   = bus.adr.io.offset[3:0];
    assign busy  = |op_q;
    assign start = bus.stb && !busy && !ack_q;

    always_comb begin
        op_dec = '0;
        if (bus.we) begin
            case (ofs)
                GCU_WRITE_REG:         op_dec[0] = 1'b1;
                GCU_SELECT_REG:        op_dec[1] = 1'b1;
                GCU_RAM_H, GCU_RAM_L:  op_dec[2] = 1'b1; // either half writes RAM
                GCU_RAM_PTR:           op_dec[5] = 1'b1;
                default: ;
            endcase
        end else begin
            case (ofs)
                GCU_RAM_H: op_dec[3] = 1'b1;
                GCU_RAM_L: op_dec[4] = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            op_q  <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (busy && gcu_ack) begin
                op_q  <= '0;
                ack_q <= 1'b1;
            end else if (start) begin
                op_q  <= op_dec;
                ack_q <= ~|op_dec; // nothing to do, answer at once
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (busy && gcu_ack)
            dat_q <= gcu_dout;
        else if (start)
            dat_q <= '0;
    end

    assign {gcu_op_set_ram_ptr, gcu_op_read_ram_l, gcu_op_read_ram_h,
            gcu_op_write_ram, gcu_op_select_reg, gcu_op_write_reg} = op_q;

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;

    a_one_op: assert property (@(posedge CLK96) disable iff (RESET96) $onehot0(op_q));

endmodule

/* hdl/io_ports.sv */
// cabinet and sound I/O registers
`timescale 1ns/1ns

module io_ports import batrider_map_pkg::*, batrider_io_pkg::*; (
    input  logic        CLK96,
    input  logic        RESET96,
    region_bus_if.slave bus,
    input  logic [9:0]  joystick1,
    input  logic [9:0]  joystick2,
    input  logic [3:0]  start_button,
    input  logic [3:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [7:0]  dipsw_c,
    input  logic [8:0]  v_count,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        fblank,
    input  logic [7:0]  sound_latch3,
    input  logic [7:0]  sound_latch4,
    input  logic        snd_irq_in,
    output logic [7:0]  sound_latch,
    output logic [7:0]  sound_latch2,
    output logic [15:0] z80_busreq,
    output logic        snd_irq
);

    logic [DATA_W-1:0] rd_mux;
    logic [DATA_W-1:0] rd_q;
    logic [DATA_W-1:0] vstatus;
    logic [7:0]        ofs;
    logic              ack_q;
    logic              go;
    logic              clr_irq;
    logic              irq_in_q;

    // cabinet lines are active low, the game wants active high
    function automatic logic [7:0] player_byte(input logic [9:0] joy);
        return {1'b0, ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign ofs     = bus.adr.io.offset;
    assign go      = bus.stb && !ack_q;
    assign clr_irq = go && bus.we && (ofs == IO_CLR_SNDIRQ);

    always_comb begin
        vstatus = 16'hFF00;
        vstatus[VST_HSYNC]  = hsync;
        vstatus[VST_VSYNC]  = vsync;
        vstatus[VST_FBLANK] = fblank;
        vstatus[7:0] = (v_count < VST_LINES) ? v_count[7:0] : 8'hFF; // clamp past last line
    end

    always_comb begin
        case (ofs)
            IO_INPUTS:    rd_mux = {player_byte(joystick2), player_byte(joystick1)};
            IO_SYS_DSW:   rd_mux = {dipsw_c, 1'b0, ~start_button[1], ~start_button[0],
                                    ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0, ~service};
            IO_DSW:       rd_mux = {dipsw_b, dipsw_a};
            IO_VSTATUS:   rd_mux = vstatus;
            IO_SNDLATCH3: rd_mux = {8'h00, sound_latch3};
            IO_SNDLATCH4: rd_mux = {8'h00, sound_latch4};
            IO_BUSREQ_RD: rd_mux = z80_busreq;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge CLK96) begin
        if (go)
            rd_q <= rd_mux;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            ack_q        <= 1'b0;
            sound_latch  <= '0;
            sound_latch2 <= '0;
            z80_busreq   <= '0;
            irq_in_q     <= 1'b0;
            snd_irq      <= 1'b0;
        end else begin
            ack_q    <= go;
            irq_in_q <= snd_irq_in;
            if (go && bus.we) begin
                case (ofs)
                    IO_SNDLATCH:  sound_latch  <= bus.dat_w[7:0];
                    IO_SNDLATCH2: sound_latch2 <= bus.dat_w[7:0];
                    IO_BUSREQ_WR: z80_busreq   <= bus.dat_w;
                    default: ;
                endcase
            end
            if (snd_irq_in && !irq_in_q)
                snd_irq <= 1'b1; // a fresh edge beats the clear
            else if (clr_irq)
                snd_irq <= 1'b0;
        end
    end

    assign bus.dat_r = rd_q;
    assign bus.ack   = ack_q;

endmodule

/* hdl/byte_lane_ram.sv */
// 16K word RAM with byte lanes
`timescale 1ns/1ns

module byte_lane_ram import batrider_map_pkg::*; (
    input  logic        CLK96,
    input  logic        RESET96,
    region_bus_if.slave bus
);

    logic [DATA_W-1:0] mem [2**RAM_AW];
    logic [DATA_W-1:0] rd_q;
    logic [RAM_AW-1:0] idx;
    logic              ack_q;
    logic              go;

    assign idx = bus.adr.map.word;
    assign go  = bus.stb && !ack_q; // one access per strobe

    always_ff @(posedge CLK96) begin
        if (go) begin
            if (bus.we) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (bus.sel[i])
                        mem[idx][i*8 +: 8] <= bus.dat_w[i*8 +: 8];
                end
            end
            rd_q <= mem[idx]; // old word on a write
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96)
            ack_q <= 1'b0;
        else
            ack_q <= go;
    end

    assign bus.dat_r = rd_q;
    assign bus.ack   = ack_q;

endmodule

/* hdl/bus_decoder.sv */
// main bus region decoder
`timescale 1ns/1ns

module bus_decoder import batrider_map_pkg::*; (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [SEL_W-1:0]    wb_sel,
    input  logic [ADDR_W-1:1]   wb_adr,
    input  logic [DATA_W-1:0]   wb_dat_w,
    output logic [DATA_W-1:0]   wb_dat_r,
    output logic                wb_ack,
    region_bus_if.decoder       text_ram,
    region_bus_if.decoder       work_ram,
    region_bus_if.decoder       io,
    region_bus_if.decoder       gcu
);

    bus_addr_u  adr_u;
    logic [4:0] dec;    // {unmapped, gcu, io, work, text}
    logic [4:0] sel_q;
    logic       un_ack;
    logic       start;

    assign adr_u = {wb_adr, 1'b0}; // no A0 on the 68000
    assign start = wb_cyc && wb_stb && !(|sel_q);

    always_comb begin
        dec = '0;
        case (adr_u.map.region)
            REGION_RAM: dec[adr_u.map.bank] = 1'b1;
            REGION_IO:  dec[2] = 1'b1;
            REGION_GCU: dec[3] = 1'b1;
            default:    dec[4] = 1'b1;
        endcase
    end

    // one region per access, held until its ack
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel_q  <= '0;
            un_ack <= 1'b0;
        end else begin
            un_ack <= sel_q[4] && !un_ack; // unmapped, answer ourselves
            if (wb_ack)
                sel_q <= '0;
            else if (start)
                sel_q <= dec;
        end
    end

    assign {gcu.stb, io.stb, work_ram.stb, text_ram.stb} = sel_q[3:0];
    assign {text_ram.we, work_ram.we, io.we, gcu.we} = {4{wb_we}};
    assign {text_ram.sel, work_ram.sel, io.sel, gcu.sel} = {4{wb_sel}};
    assign {text_ram.adr, work_ram.adr, io.adr, gcu.adr} = {4{adr_u}};
    assign {text_ram.dat_w, work_ram.dat_w, io.dat_w, gcu.dat_w} = {4{wb_dat_w}};

    assign wb_ack = |(sel_q & {un_ack, gcu.ack, io.ack, work_ram.ack, text_ram.ack});

    always_comb begin
        wb_dat_r = '0; // unmapped reads as zero
        if (sel_q[0]) wb_dat_r = text_ram.dat_r;
        if (sel_q[1]) wb_dat_r = work_ram.dat_r;
        if (sel_q[2]) wb_dat_r = io.dat_r;
        if (sel_q[3]) wb_dat_r = gcu.dat_r;
    end

    a_one_slave: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0({text_ram.stb, work_ram.stb, io.stb, gcu.stb}));

    a_ack_in_strobe: assert property (@(posedge CLK96) disable iff (RESET96)
        $rose(wb_ack) |-> wb_stb);

endmodule

/* hdl/region_bus_if.sv */
// decoder to region slave link
`timescale 1ns/1ns

interface region_bus_if import batrider_map_pkg::*; ();

    logic              stb;
    logic              we;
    logic [SEL_W-1:0]  sel;
    bus_addr_u         adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    modport decoder (
        output stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  stb, we, sel, adr, dat_w,
        output dat_r, ack
    );

endinterface

/* hdl/batrider_io_pkg.sv */
// I/O and video controller register map
package batrider_io_pkg;

    // read side of the 0x5000xx block
    localparam logic [7:0] IO_INPUTS    = 8'h00;
    localparam logic [7:0] IO_SYS_DSW   = 8'h02;
    localparam logic [7:0] IO_DSW       = 8'h04;
    localparam logic [7:0] IO_VSTATUS   = 8'h06;
    localparam logic [7:0] IO_SNDLATCH3 = 8'h08;
    localparam logic [7:0] IO_SNDLATCH4 = 8'h0A;
    localparam logic [7:0] IO_BUSREQ_RD = 8'h0C;

    // write side
    localparam logic [7:0] IO_SNDLATCH   = 8'h20;
    localparam logic [7:0] IO_SNDLATCH2  = 8'h22;
    localparam logic [7:0] IO_CLR_SNDIRQ = 8'h26;
    localparam logic [7:0] IO_BUSREQ_WR  = 8'h60;

    // video controller, low nibble of 0x4000xx
    localparam logic [3:0] GCU_WRITE_REG  = 4'h0;
    localparam logic [3:0] GCU_SELECT_REG = 4'h4;
    localparam logic [3:0] GCU_RAM_H      = 4'h8;
    localparam logic [3:0] GCU_RAM_L      = 4'hA;
    localparam logic [3:0] GCU_RAM_PTR    = 4'hC;

    localparam int VST_HSYNC  = 15;
    localparam int VST_VSYNC  = 14;
    localparam int VST_FBLANK = 8;
    localparam int VST_LINES  = 256; // counts at or above this read as 0xFF

endpackage

/* hdl/batrider_map_pkg.sv */
// main bus memory map
package batrider_map_pkg;

    localparam int ADDR_W   = 24; // 68000 byte address
    localparam int RAM_AW   = 14; // 16K words per RAM
    localparam int DATA_W   = 16;
    localparam int SEL_W    = 2;  // byte lanes
    localparam int REGION_W = 4;
    localparam int IO_OFS_W = 8;

    // region number sits in address bits 23:20
    localparam logic [REGION_W-1:0] REGION_RAM = 4'h2;
    localparam logic [REGION_W-1:0] REGION_GCU = 4'h4;
    localparam logic [REGION_W-1:0] REGION_IO  = 4'h5;
    localparam int RAM_BANK_BIT = 15; // low picks text RAM, high work RAM

    typedef struct packed {
        logic [REGION_W-1:0]                     region;
        logic [ADDR_W-REGION_W-RAM_BANK_BIT-2:0] pad;    // bits 19:16, ignored
        logic                                    bank;
        logic [RAM_AW-1:0]                       word;
        logic                                    byte_bit;
    } map_view_t;

    typedef struct packed {
        logic [ADDR_W-IO_OFS_W-1:0] upper;
        logic [IO_OFS_W-1:0]        offset;
    } io_view_t;

    // same byte address, seen by the decoder or by a register block
    typedef union packed {
        map_view_t map;
        io_view_t  io;
    } bus_addr_u;

endpackage
